// ==== src/frame_pkg.sv ====
`default_nettype none

package frame_pkg;

    // Word memory geometry
    localparam int ADDR_W    = 10;
    localparam int DATA_W    = 16;
    localparam int MASK_W    = 2;              // One bit per byte lane, 1 = write
    localparam int LANE_W    = DATA_W / MASK_W;

    // Game side banks
    localparam int NBANKS    = 4;
    localparam int BANK_W    = $clog2(NBANKS);

    // Request sources seen by the arbiter, banks first and the loader last
    localparam int SRC_W     = $clog2(NBANKS + 1);
    localparam logic [SRC_W-1:0] PROG_ID = SRC_W'(NBANKS);

    // Accept to data valid, in cycles
    localparam int MEM_LAT   = 2;

    // Download stream is byte addressed
    localparam int DL_ADDR_W = ADDR_W + 1;

    // One memory operation, 29 bits
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic              wr;
        logic [DATA_W-1:0] data;
        logic [MASK_W-1:0] mask;
    } mem_req_t;

endpackage

`default_nettype wire

// ==== src/bank_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface bank_if;
    import frame_pkg::*;

    // Requester side
    logic [ADDR_W-1:0] addr;
    logic              rd;
    logic              wr;
    logic [DATA_W-1:0] din;
    logic [MASK_W-1:0] din_m;      // Write lane mask

    // Server side
    logic              ack;        // Grant pulse
    logic              dst;        // Data start
    logic              dok;        // Data valid on dout
    logic              rdy;        // Operation done
    logic [DATA_W-1:0] dout;

    modport requester (
        output addr, rd, wr, din, din_m,
        input  ack, dst, dok, rdy, dout
    );

    modport server (
        input  addr, rd, wr, din, din_m,
        output ack, dst, dok, rdy, dout
    );

endinterface

`default_nettype wire

// ==== src/rom_loader.sv ====
`timescale 1ns/100ps
`default_nettype none

module rom_loader (
    input  logic                            sample,
    input  logic                            rst_n,
    input  logic                            downloading,
    input  logic [frame_pkg::DL_ADDR_W-1:0] ioctl_addr,
    input  logic [7:0]                      ioctl_data,
    input  logic                            ioctl_wr,
    output logic                            dwnld_busy,
    bank_if.requester                       prog
);
    import frame_pkg::*;

    // One entry buffer for the byte waiting to be written
    logic [ADDR_W-1:0] addr_q;
    logic [LANE_W-1:0] byte_q;
    logic [MASK_W-1:0] mask_q;
    logic              take;

    // A strobe outside a download is not ours
    assign take = ioctl_wr & downloading & ~dwnld_busy;

    always_ff @(posedge sample) begin
        if (take) begin
            addr_q <= ioctl_addr[DL_ADDR_W-1:1];       // Byte to word address
            byte_q <= ioctl_data;
            mask_q <= MASK_W'(1) << ioctl_addr[0];     // Odd byte goes to the high lane
        end
    end

    // Busy from capture until the arbiter takes the write
    always_ff @(posedge sample or negedge rst_n) begin
        if (!rst_n) begin
            dwnld_busy <= 1'b0;
        end else if (take) begin
            dwnld_busy <= 1'b1;
        end else if (prog.ack) begin
            dwnld_busy <= 1'b0;
        end
    end

    // The pending write is held on the bus until ack
    assign prog.addr  = addr_q;
    assign prog.wr    = dwnld_busy;
    assign prog.rd    = 1'b0;                          // Loader only writes
    assign prog.din   = {MASK_W{byte_q}};              // Same byte on both lanes
    assign prog.din_m = mask_q;

endmodule

`default_nettype wire

// ==== src/bank_arbiter.sv ====
`timescale 1ns/100ps
`default_nettype none

module bank_arbiter (
    input  logic                         sample,
    input  logic                         rst_n,
    input  logic                         downloading,
    bank_if.server                       prog,
    bank_if.server                       bank [frame_pkg::NBANKS],
    output frame_pkg::mem_req_t          mem_req,
    output logic                         mem_valid,
    input  logic [frame_pkg::DATA_W-1:0] mem_dout,
    input  logic                         mem_dout_valid
);
    import frame_pkg::*;

    logic [NBANKS-1:0] bank_req;
    logic [NBANKS-1:0] bank_ack;
    logic [ADDR_W-1:0] bank_addr [NBANKS];
    logic              bank0_wr;
    logic [DATA_W-1:0] bank0_din;
    logic [MASK_W-1:0] bank0_din_m;

    logic [BANK_W-1:0] rr_ptr;
    logic [BANK_W-1:0] rr_sel;
    logic              rr_hit;
    logic              prog_req;
    logic              bank_gnt;
    logic              gnt_wr;
    logic [SRC_W-1:0]  gnt_id;

    // Reads in flight, one stage per memory cycle
    logic [MEM_LAT-1:0] fl_vld;
    logic [SRC_W-1:0]   fl_id [MEM_LAT];

    logic              ret;
    logic [NBANKS:0]   ret_hot;           // Returning source, loader on the top bit
    logic [NBANKS:0]   rdy_q;
    logic [DATA_W-1:0] hold [NBANKS+1];   // Last word per source, kept for the rdy cycle

    // Flatten the bank interfaces
    for (genvar i = 0; i < NBANKS; i++) begin : g_bank
        assign bank_addr[i] = bank[i].addr;
        if (i == 0) begin : g_rw
            assign bank_req[i] = bank[i].rd | bank[i].wr;
        end else begin : g_ro
            assign bank_req[i] = bank[i].rd;   // Write strobe ignored here
        end
        assign bank[i].ack  = bank_ack[i];
        assign bank[i].dst  = ret_hot[i];
        assign bank[i].dok  = ret_hot[i];
        assign bank[i].rdy  = rdy_q[i] | (bank_ack[i] & gnt_wr);
        assign bank[i].dout = ret_hot[i] ? mem_dout : hold[i];
    end

    assign bank0_wr    = bank[0].wr;
    assign bank0_din   = bank[0].din;
    assign bank0_din_m = bank[0].din_m;

    // First requesting bank at or after the pointer
    always_comb begin
        rr_hit = 1'b0;
        rr_sel = rr_ptr;
        for (int i = NBANKS - 1; i >= 0; i--) begin
            if (bank_req[rr_ptr + BANK_W'(i)]) begin
                rr_hit = 1'b1;
                rr_sel = rr_ptr + BANK_W'(i);
            end
        end
    end

    // Loader always goes first, banks wait out the download
    assign prog_req  = prog.rd | prog.wr;
    assign bank_gnt  = rr_hit & ~downloading & ~prog_req;
    assign mem_valid = prog_req | bank_gnt;
    assign bank_ack  = NBANKS'(bank_gnt) << rr_sel;
    assign gnt_id    = prog_req ? PROG_ID : SRC_W'(rr_sel);
    assign gnt_wr    = prog_req ? prog.wr : (bank_gnt && rr_sel == '0 && bank0_wr);

    always_comb begin
        if (prog_req) begin
            mem_req.addr = prog.addr;
            mem_req.wr   = prog.wr;
            mem_req.data = prog.din;
            mem_req.mask = prog.din_m;
        end else begin
            mem_req.addr = bank_addr[rr_sel];
            mem_req.wr   = gnt_wr;
            mem_req.data = bank0_din;     // Only bank 0 carries write data
            mem_req.mask = bank0_din_m;
        end
    end

    always_ff @(posedge sample or negedge rst_n) begin
        if (!rst_n) begin
            rr_ptr <= '0;
            fl_vld <= '0;
            rdy_q  <= '0;
            for (int s = 0; s < MEM_LAT; s++) begin
                fl_id[s] <= '0;
            end
        end else begin
            if (bank_gnt) begin
                rr_ptr <= rr_sel + BANK_W'(1);   // Next bank gets first look
            end
            fl_vld[0] <= mem_valid & ~gnt_wr;
            fl_id[0]  <= gnt_id;
            for (int s = 1; s < MEM_LAT; s++) begin
                fl_vld[s] <= fl_vld[s-1];
                fl_id[s]  <= fl_id[s-1];
            end
            rdy_q <= ret_hot;                    // rdy trails dok by one cycle
        end
    end

    // Tail of the in-flight register lines up with memory data
    assign ret     = fl_vld[MEM_LAT-1] & mem_dout_valid;
    assign ret_hot = (NBANKS + 1)'(ret) << fl_id[MEM_LAT-1];

    always_ff @(posedge sample) begin
        for (int s = 0; s <= NBANKS; s++) begin
            if (ret_hot[s]) begin
                hold[s] <= mem_dout;
            end
        end
    end

    // Loader side of the same protocol
    assign prog.ack  = prog_req;
    assign prog.dst  = ret_hot[NBANKS];
    assign prog.dok  = ret_hot[NBANKS];
    assign prog.rdy  = rdy_q[NBANKS] | (prog_req & prog.wr);
    assign prog.dout = ret_hot[NBANKS] ? mem_dout : hold[NBANKS];

endmodule

`default_nettype wire

// ==== src/word_memory.sv ====
`timescale 1ns/100ps
`default_nettype none

module word_memory (
    input  logic                         sample,
    input  logic                         rst_n,
    input  frame_pkg::mem_req_t          mem_req,
    input  logic                         mem_valid,
    output logic [frame_pkg::DATA_W-1:0] mem_dout,
    output logic                         mem_dout_valid
);
    import frame_pkg::*;

    logic [DATA_W-1:0]  mem [2**ADDR_W];
    logic [DATA_W-1:0]  rd_data [MEM_LAT];
    logic [MEM_LAT-1:0] rd_vld;
    logic               do_wr;
    logic               do_rd;

    assign do_wr = mem_valid & mem_req.wr;
    assign do_rd = mem_valid & ~mem_req.wr;

    // Lane writes land in the accept cycle
    always_ff @(posedge sample) begin
        if (do_wr) begin
            for (int b = 0; b < MASK_W; b++) begin
                if (mem_req.mask[b]) begin
                    mem[mem_req.addr][b*LANE_W +: LANE_W] <= mem_req.data[b*LANE_W +: LANE_W];
                end
            end
        end
    end

    // Read data pipeline
    always_ff @(posedge sample) begin
        rd_data[0] <= mem[mem_req.addr];
        for (int s = 1; s < MEM_LAT; s++) begin
            rd_data[s] <= rd_data[s-1];
        end
    end

    always_ff @(posedge sample or negedge rst_n) begin
        if (!rst_n) begin
            rd_vld <= '0;
        end else begin
            rd_vld[0] <= do_rd;
            for (int s = 1; s < MEM_LAT; s++) begin
                rd_vld[s] <= rd_vld[s-1];
            end
        end
    end

    assign mem_dout       = rd_data[MEM_LAT-1];
    assign mem_dout_valid = rd_vld[MEM_LAT-1];   // MEM_LAT cycles after accept

endmodule

`default_nettype wire

// ==== src/mem_frame_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_frame_top (
    input  logic                            sample,
    input  logic                            rst_n,
    // ROM download
    input  logic                            downloading,
    input  logic [frame_pkg::DL_ADDR_W-1:0] ioctl_addr,
    input  logic [7:0]                      ioctl_data,
    input  logic                            ioctl_wr,
    output logic                            dwnld_busy,
    // Game banks, bank 0 reads and writes
    input  logic [frame_pkg::ADDR_W-1:0]    ba0_addr,
    input  logic [frame_pkg::ADDR_W-1:0]    ba1_addr,
    input  logic [frame_pkg::ADDR_W-1:0]    ba2_addr,
    input  logic [frame_pkg::ADDR_W-1:0]    ba3_addr,
    input  logic [frame_pkg::NBANKS-1:0]    ba_rd,
    input  logic                            ba_wr,
    input  logic [frame_pkg::DATA_W-1:0]    ba0_din,
    input  logic [frame_pkg::MASK_W-1:0]    ba0_din_m,
    output logic [frame_pkg::NBANKS-1:0]    ba_ack,
    output logic [frame_pkg::NBANKS-1:0]    ba_dst,
    output logic [frame_pkg::NBANKS-1:0]    ba_dok,
    output logic [frame_pkg::NBANKS-1:0]    ba_rdy,
    output logic [frame_pkg::DATA_W-1:0]    data_read
);
    import frame_pkg::*;

    mem_req_t          mem_req;
    logic              mem_valid;
    logic [DATA_W-1:0] mem_dout;
    logic              mem_dout_valid;

    bank_if prog ();
    bank_if bank [NBANKS] ();

    assign bank[0].addr = ba0_addr;
    assign bank[1].addr = ba1_addr;
    assign bank[2].addr = ba2_addr;
    assign bank[3].addr = ba3_addr;

    for (genvar i = 0; i < NBANKS; i++) begin : g_bank
        assign bank[i].rd = ba_rd[i];
        assign ba_ack[i]  = bank[i].ack;
        assign ba_dst[i]  = bank[i].dst;
        assign ba_dok[i]  = bank[i].dok;
        assign ba_rdy[i]  = bank[i].rdy;
        if (i == 0) begin : g_rw
            assign bank[i].wr    = ba_wr;
            assign bank[i].din   = ba0_din;
            assign bank[i].din_m = ba0_din_m;
        end else begin : g_ro
            assign bank[i].wr    = 1'b0;   // Read only banks
            assign bank[i].din   = '0;
            assign bank[i].din_m = '0;
        end
    end

    // Shared read bus, valid alongside dok
    assign data_read = mem_dout;

    rom_loader u_loader (
        .sample      ( sample      ),
        .rst_n       ( rst_n       ),
        .downloading ( downloading ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_data  ( ioctl_data  ),
        .ioctl_wr    ( ioctl_wr    ),
        .dwnld_busy  ( dwnld_busy  ),
        .prog        ( prog        )
    );

    bank_arbiter u_arbiter (
        .sample         ( sample         ),
        .rst_n          ( rst_n          ),
        .downloading    ( downloading    ),
        .prog           ( prog           ),
        .bank           ( bank           ),
        .mem_req        ( mem_req        ),
        .mem_valid      ( mem_valid      ),
        .mem_dout       ( mem_dout       ),
        .mem_dout_valid ( mem_dout_valid )
    );

    word_memory u_memory (
        .sample         ( sample         ),
        .rst_n          ( rst_n          ),
        .mem_req        ( mem_req        ),
        .mem_valid      ( mem_valid      ),
        .mem_dout       ( mem_dout       ),
        .mem_dout_valid ( mem_dout_valid )
    );

endmodule

`default_nettype wire

// ==== sim/mem_frame_properties.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_frame_properties (
    input logic                         sample,
    input logic                         rst_n,
    input logic                         downloading,
    input logic [frame_pkg::NBANKS-1:0] bank_ack,
    input logic [frame_pkg::NBANKS:0]   ret_hot,
    input logic [frame_pkg::NBANKS:0]   rdy_q,
    input logic                         prog_req
);
    import frame_pkg::*;

    logic [NBANKS-1:0] dok;
    logic [NBANKS-1:0] rdy;

    assign dok = ret_hot[NBANKS-1:0];   // Loader bit dropped
    assign rdy = rdy_q[NBANKS-1:0];     // Read completions only

    ack_one_hot: assert property (@(posedge sample) disable iff (!rst_n)
        $onehot0(bank_ack))
        else $error("more than one bank acked in the same cycle");

    // Same bank must see rdy right after its dok
    dok_then_rdy: assert property (@(posedge sample) disable iff (!rst_n)
        (|dok) |=> ((rdy & $past(dok)) == $past(dok)))
        else $error("dok was not followed by rdy on the same bank");

    no_ack_in_download: assert property (@(posedge sample) disable iff (!rst_n)
        downloading |-> (bank_ack == '0))
        else $error("bank acked while downloading was high");

    busy_clear_after_reset: assert property (@(posedge sample)
        $rose(rst_n) |-> !prog_req)
        else $error("dwnld_busy high when reset was released");

endmodule

`default_nettype wire

// ==== sim/tb_mem_frame.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_mem_frame;
    import frame_pkg::*;

    typedef enum logic [2:0] {OP_DL, OP_RD, OP_WR, OP_ALL, OP_BLK} op_t;
    typedef struct packed {
        op_t                  op;
        logic [BANK_W-1:0]    bank;
        logic [DL_ADDR_W-1:0] addr;       // Byte address for downloads, word address otherwise
        logic [DATA_W-1:0]    data;
        logic [MASK_W-1:0]    mask;
        logic [DATA_W-1:0]    exp_data;
    } row_t;

    logic sample, rst_n, downloading, ioctl_wr, dwnld_busy, ba_wr;
    logic [DL_ADDR_W-1:0] ioctl_addr;
    logic [7:0]           ioctl_data;
    logic [ADDR_W-1:0]    ba0_addr, ba1_addr, ba2_addr, ba3_addr;
    logic [NBANKS-1:0]    ba_rd, ba_ack, ba_dst, ba_dok, ba_rdy;
    logic [DATA_W-1:0]    ba0_din, data_read;
    logic [MASK_W-1:0]    ba0_din_m;

    row_t              rows [$];
    logic [DATA_W-1:0] ref_mem [2**ADDR_W];
    int                errors = 0;
    int                cyc = 0;
    int                cyc_limit = 0;

    mem_frame_top UUT (.*);

    bind bank_arbiter mem_frame_properties u_props (
        .sample(sample), .rst_n(rst_n), .downloading(downloading), .bank_ack(bank_ack),
        .ret_hot(ret_hot), .rdy_q(rdy_q), .prog_req(prog_req)
    );

    initial begin
        sample = 1'b0;
        forever #10 sample = ~sample;
    end

    always @(posedge sample) begin
        cyc <= cyc + 1;
        if (cyc_limit != 0 && cyc > cyc_limit) begin
            $display("Timeout, the run did not finish within %0d cycles", cyc_limit);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("Error: %s got %h expected %h", name, got, exp);
        end
    endtask

    // Only lanes with a set mask bit take the new data
    function automatic logic [DATA_W-1:0] merge_lanes(input logic [DATA_W-1:0] old,
            input logic [DATA_W-1:0] wdata, input logic [MASK_W-1:0] m);
        logic [DATA_W-1:0] sel;
        for (int b = 0; b < MASK_W; b++) begin
            sel[b*LANE_W +: LANE_W] = {LANE_W{m[b]}};
        end
        return (old & ~sel) | (wdata & sel);
    endfunction

    task automatic add_row(input op_t op, input logic [BANK_W-1:0] bank,
            input logic [DL_ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
            input logic [MASK_W-1:0] mask);
        row_t              r;
        logic [ADDR_W-1:0] w;
        r = '{op: op, bank: bank, addr: addr, data: data, mask: mask, exp_data: '0};
        w = addr[ADDR_W-1:0];
        case (op)
            OP_DL: begin
                w = addr[DL_ADDR_W-1:1];                           // Odd byte is the high lane
                ref_mem[w] = merge_lanes(ref_mem[w], {2{data[7:0]}}, addr[0] ? 2'b10 : 2'b01);
            end
            OP_WR: ref_mem[w] = merge_lanes(ref_mem[w], data, mask);
            OP_RD, OP_BLK: r.exp_data = ref_mem[w];
            default: ;
        endcase
        rows.push_back(r);
    endtask

    task automatic build_table();
        logic [MASK_W-1:0] wmask [5];
        wmask = '{2'b11, 2'b00, 2'b01, 2'b10, 2'b11};
        for (int k = 0; k < 64; k++) begin
            add_row(OP_DL, '0, DL_ADDR_W'(k), DATA_W'($urandom), '0);
        end
        for (int k = 0; k < 32; k++) begin
            add_row(OP_RD, 2'd1, DL_ADDR_W'(k), '0, '0);
        end
        for (int k = 0; k < 5; k++) begin
            add_row(OP_WR, '0, DL_ADDR_W'(40), DATA_W'($urandom), wmask[k]);
            add_row(OP_RD, 2'd2, DL_ADDR_W'(40), '0, '0);
        end
        // Words 0..31 stay as downloaded, so the final reference holds for these
        for (int k = 0; k < 3; k++) begin
            add_row(OP_ALL, '0, DL_ADDR_W'(8 * k), '0, '0);
        end
        add_row(OP_BLK, 2'd3, DL_ADDR_W'(5), '0, '0);
        add_row(OP_BLK, 2'd0, DL_ADDR_W'(30), '0, '0);
    endtask

    task automatic drive_addr(input int i, input logic [ADDR_W-1:0] a);
        case (i)
            0: ba0_addr = a;
            1: ba1_addr = a;
            2: ba2_addr = a;
            default: ba3_addr = a;
        endcase
    endtask

    task automatic download_byte(input logic [DL_ADDR_W-1:0] a, input logic [7:0] d);
        downloading = 1'b1;
        while (dwnld_busy) begin
            @(posedge sample);
            #2;
        end
        ioctl_addr = a;
        ioctl_data = d;
        ioctl_wr   = 1'b1;   // One cycle strobe
        @(posedge sample);
        #2;
        ioctl_wr = 1'b0;
        assert (dwnld_busy) else begin
            errors++;
            $display("dwnld_busy did not rise after the strobe for byte %h", a);
        end
        while (dwnld_busy) begin
            @(posedge sample);
            #2;
        end
    endtask

    task automatic bank0_write(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d,
            input logic [MASK_W-1:0] m);
        logic got;
        got = 1'b0;
        downloading = 1'b0;
        ba0_addr  = a;
        ba0_din   = d;
        ba0_din_m = m;
        ba_wr     = 1'b1;
        while (!got) begin
            @(negedge sample);
            if (ba_ack[0]) begin
                got = 1'b1;
                check_value("ba_rdy[0] with write ack", 32'(ba_rdy[0]), 32'd1);
                check_value("ba_dst on write", 32'(ba_dst), 32'd0);
                check_value("ba_dok on write", 32'(ba_dok), 32'd0);
            end
            @(posedge sample);
            #2;
        end
        ba_wr = 1'b0;
    endtask

    // Reads on a set of banks, each held until ack, then next address NBANKS words on
    task automatic run_reads(input logic [NBANKS-1:0] banks, input logic [ADDR_W-1:0] base,
            input int spread, input int per_bank, input int hold,
            input logic use_exp, input logic [DATA_W-1:0] exp_w);
        int                left [NBANKS];
        int                acks [NBANKS];
        int                ack_at [NBANKS];
        logic [ADDR_W-1:0] cur [NBANKS];
        logic [DATA_W-1:0] want [NBANKS];
        logic [NBANKS-1:0] acked;
        logic [NBANKS-1:0] pend;
        logic              exp_dok;
        logic              exp_rdy;
        int                total;
        int                done;
        total = 0;
        done  = 0;
        pend  = '0;
        for (int i = 0; i < NBANKS; i++) begin
            left[i]   = banks[i] ? per_bank : 0;
            acks[i]   = 0;
            ack_at[i] = 0;
            want[i]   = '0;
            cur[i]    = base + ADDR_W'(spread * i);
            total    += left[i];
            drive_addr(i, cur[i]);
        end
        ba_rd = banks;
        downloading = (hold > 0);
        repeat (hold) begin
            @(negedge sample);
            assert (ba_ack == '0) else begin
                errors++;
                $display("A bank was acked while downloading was high");
            end
            @(posedge sample);
            #2;
        end
        downloading = 1'b0;
        while (done < total) begin
            @(negedge sample);
            acked = ba_ack;
            assert ((ba_ack & ~ba_rd) == '0) else begin
                errors++;
                $display("A bank without a request was acked");
            end
            for (int i = 0; i < NBANKS; i++) begin
                // Data MEM_LAT cycles after ack, done one cycle later
                exp_dok = pend[i] && (cyc - ack_at[i] == MEM_LAT);
                exp_rdy = pend[i] && (cyc - ack_at[i] == MEM_LAT + 1);
                check_value($sformatf("ba_dst[%0d]", i), 32'(ba_dst[i]), 32'(exp_dok));
                check_value($sformatf("ba_dok[%0d]", i), 32'(ba_dok[i]), 32'(exp_dok));
                check_value($sformatf("ba_rdy[%0d]", i), 32'(ba_rdy[i]), 32'(exp_rdy));
                if (exp_dok) begin
                    check_value("data_read", 32'(data_read), 32'(want[i]));
                end
                if (exp_rdy) begin
                    pend[i] = 1'b0;
                    done++;
                end
                if (ba_ack[i]) begin
                    for (int j = 0; j < NBANKS; j++) begin
                        assert (acks[i] == 0 || !banks[j] || acks[j] > 0) else begin
                            errors++;
                            $display("Bank %0d got a second ack before bank %0d got one", i, j);
                        end
                    end
                    acks[i]++;
                    left[i]--;
                    ack_at[i] = cyc;
                    pend[i]   = 1'b1;
                    want[i]   = use_exp ? exp_w : ref_mem[cur[i]];
                end
            end
            @(posedge sample);
            #2;
            for (int i = 0; i < NBANKS; i++) begin
                if (acked[i] && left[i] == 0) begin
                    ba_rd[i] = 1'b0;
                end else if (acked[i]) begin
                    cur[i] = cur[i] + ADDR_W'(NBANKS);
                    drive_addr(i, cur[i]);
                end
            end
        end
    endtask

    initial begin
        rst_n = 1'b0;
        {downloading, ioctl_wr, ioctl_addr, ioctl_data} = '0;
        {ba0_addr, ba1_addr, ba2_addr, ba3_addr, ba_rd, ba_wr, ba0_din, ba0_din_m} = '0;
        void'($urandom(32'h7c487729));
        build_table();
        cyc_limit = 40 * rows.size() + 10;
        repeat (10) @(posedge sample);
        #2;
        rst_n = 1'b1;
        @(negedge sample);
        check_value("ba_ack", 32'(ba_ack), 32'd0);
        check_value("ba_dst", 32'(ba_dst), 32'd0);
        check_value("ba_dok", 32'(ba_dok), 32'd0);
        check_value("ba_rdy", 32'(ba_rdy), 32'd0);
        check_value("dwnld_busy", 32'(dwnld_busy), 32'd0);
        @(posedge sample);
        #2;
        foreach (rows[k]) begin
            case (rows[k].op)
                OP_DL:  download_byte(rows[k].addr, rows[k].data[7:0]);
                OP_WR:  bank0_write(rows[k].addr[ADDR_W-1:0], rows[k].data, rows[k].mask);
                OP_RD:  run_reads(NBANKS'(1) << rows[k].bank, rows[k].addr[ADDR_W-1:0],
                                  0, 1, 0, 1'b1, rows[k].exp_data);
                OP_ALL: run_reads('1, rows[k].addr[ADDR_W-1:0], 1, 2, 0, 1'b0, '0);
                default: run_reads(NBANKS'(1) << rows[k].bank, rows[k].addr[ADDR_W-1:0],
                                   0, 1, 8, 1'b1, rows[k].exp_data);
            endcase
        end
        $display("Applied %0d rows, %0d errors", rows.size(), errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
src/frame_pkg.sv
src/bank_if.sv
src/rom_loader.sv
src/bank_arbiter.sv
src/word_memory.sv
src/mem_frame_top.sv
sim/mem_frame_properties.sv
sim/tb_mem_frame.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the memory frame testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f sources.f --top-module tb_mem_frame -o tb_mem_frame &&
./obj_dir/tb_mem_frame | tee /dev/stderr | grep -F "ALL TESTS PASSED" > /dev/null &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
